// File: hw/rx_pkg.sv
// Sample widths, serial register addresses and field widths
// for the receive sample path, plus the sample FIFO sizing
package rx_pkg;

   // Sample and accumulator widths
   localparam int ADC_W    = 12;
   localparam int SAMPLE_W = 16;
   localparam int ACC_W    = 24;      // 256 sign-extended ADC samples fit

   // Serial settings bus
   localparam int ADDR_W   = 7;
   localparam int SERIAL_W = 32;

   localparam logic [ADDR_W-1:0] ADDR_RX_DECIM  = 7'd10;
   localparam logic [ADDR_W-1:0] ADDR_RX_MODE   = 7'd13;
   localparam logic [ADDR_W-1:0] ADDR_RX_ENABLE = 7'd14;

   // Programmed field widths
   localparam int DECIM_W = 8;
   localparam int SHIFT_W = 4;

   // Sample FIFO, one packed I/Q pair per word
   localparam int WORD_W     = 2 * SAMPLE_W;
   localparam int FIFO_DEPTH = 16;
   localparam int FIFO_AW    = 4;

endpackage

// File: hw/rx_cfg_if.sv
// Configuration bundle from the register block to the receive stages
`timescale 1ns/1ps

interface rx_cfg_if;

   logic [rx_pkg::DECIM_W-1:0] decim_m1;       // Decimation factor minus one
   logic [rx_pkg::SHIFT_W-1:0] shift;          // Right shift applied to window sums
   logic                       loopback;
   logic                       counter_mode;   // Wins over loopback
   logic                       enable_rx;

   // Register block side
   modport source (
      output decim_m1,
      output shift,
      output loopback,
      output counter_mode,
      output enable_rx
   );

   // Stage sides
   modport decim (input decim_m1, input shift, input enable_rx);

   modport mux (input loopback, input counter_mode, input enable_rx);

endinterface

// File: hw/rx_settings.sv
// Register block for the receive path
// Serial writes load decimation, mode/shift and enable settings
`timescale 1ns/1ps

module rx_settings
(
   input  logic                        clk64,
   input  logic                        rx_dsp_reset,
   input  logic                        i_serial_strobe,
   input  logic [rx_pkg::ADDR_W-1:0]   i_serial_addr,
   input  logic [rx_pkg::SERIAL_W-1:0] i_serial_data,
   rx_cfg_if.source                    cfg
);

   logic [rx_pkg::DECIM_W-1:0] decim_reg;
   logic [rx_pkg::SHIFT_W-1:0] shift_reg;
   logic [1:0]                 mode_reg;     // Bit 1 counter, bit 0 loopback
   logic                       enable_reg;

   logic wr_decim;
   logic wr_mode;
   logic wr_enable;

   // Address decode, other addresses fall through untouched
   assign wr_decim  = i_serial_strobe && (i_serial_addr == rx_pkg::ADDR_RX_DECIM);
   assign wr_mode   = i_serial_strobe && (i_serial_addr == rx_pkg::ADDR_RX_MODE);
   assign wr_enable = i_serial_strobe && (i_serial_addr == rx_pkg::ADDR_RX_ENABLE);

   // New value takes effect on the edge after the strobe cycle
   always_ff @(posedge clk64)
   begin
      if (rx_dsp_reset)
      begin
         decim_reg  <= '0;
         shift_reg  <= '0;
         mode_reg   <= '0;
         enable_reg <= 1'b0;
      end
      else
      begin
         if (wr_decim)
         begin
            decim_reg <= i_serial_data[rx_pkg::DECIM_W-1:0];
         end
         if (wr_mode)
         begin
            mode_reg  <= i_serial_data[1:0];
            shift_reg <= i_serial_data[8 +: rx_pkg::SHIFT_W];
         end
         if (wr_enable)
         begin
            enable_reg <= i_serial_data[0];
         end
      end
   end

   // Fields onto the configuration bundle
   assign cfg.decim_m1     = decim_reg;
   assign cfg.shift        = shift_reg;
   assign cfg.loopback     = mode_reg[0];
   assign cfg.counter_mode = mode_reg[1];
   assign cfg.enable_rx    = enable_reg;

endmodule

// File: hw/rx_decimator.sv
// Integrate-and-dump decimator for the I and Q ADC streams
`timescale 1ns/1ps

module rx_decimator
(
   input  logic                               clk64,
   input  logic                               rx_dsp_reset,
   rx_cfg_if.decim                            cfg,
   input  logic signed [rx_pkg::ADC_W-1:0]    i_adc_i,
   input  logic signed [rx_pkg::ADC_W-1:0]    i_adc_q,
   output logic                               o_dec_strobe,
   output logic signed [rx_pkg::SAMPLE_W-1:0] o_dec_i,
   output logic signed [rx_pkg::SAMPLE_W-1:0] o_dec_q
);

   localparam int EXT_W = rx_pkg::ACC_W - rx_pkg::ADC_W;

   logic [rx_pkg::DECIM_W-1:0]      win_cnt;
   logic                            win_first;
   logic                            win_last;

   logic signed [rx_pkg::ACC_W-1:0] ext_i;
   logic signed [rx_pkg::ACC_W-1:0] ext_q;
   logic signed [rx_pkg::ACC_W-1:0] acc_i;
   logic signed [rx_pkg::ACC_W-1:0] acc_q;
   logic signed [rx_pkg::ACC_W-1:0] sum_i;
   logic signed [rx_pkg::ACC_W-1:0] sum_q;

   // Arithmetic shift of a window sum, truncated to the output width
   function automatic logic signed [rx_pkg::SAMPLE_W-1:0] scale_sum
   (
      input logic signed [rx_pkg::ACC_W-1:0] sum,
      input logic [rx_pkg::SHIFT_W-1:0]      sh
   );
      logic signed [rx_pkg::ACC_W-1:0] shifted;
      shifted = sum >>> sh;
      return shifted[rx_pkg::SAMPLE_W-1:0];
   endfunction

   assign ext_i = {{EXT_W{i_adc_i[rx_pkg::ADC_W-1]}}, i_adc_i};
   assign ext_q = {{EXT_W{i_adc_q[rx_pkg::ADC_W-1]}}, i_adc_q};

   assign win_first = (win_cnt == '0);
   assign win_last  = (win_cnt == cfg.decim_m1);

   // First sample of a window reloads the accumulator
   assign sum_i = win_first ? ext_i : acc_i + ext_i;
   assign sum_q = win_first ? ext_q : acc_q + ext_q;

   // Window counter and dump strobe, restarted while disabled
   always_ff @(posedge clk64)
   begin
      if (rx_dsp_reset || !cfg.enable_rx)
      begin
         win_cnt      <= '0;
         o_dec_strobe <= 1'b0;
      end
      else
      begin
         o_dec_strobe <= win_last;
         if (win_last)
            win_cnt <= '0;
         else
            win_cnt <= win_cnt + 1'b1;
      end
   end

   // Accumulators and dumped samples
   always_ff @(posedge clk64)
   begin
      if (cfg.enable_rx)
      begin
         acc_i <= sum_i;
         acc_q <= sum_q;
         if (win_last)
         begin
            o_dec_i <= scale_sum(sum_i, cfg.shift);
            o_dec_q <= scale_sum(sum_q, cfg.shift);
         end
      end
   end

endmodule

// File: hw/rx_source_mux.sv
// Receive source selection between decimated samples, transmit
// loopback and a debug counter pair
`timescale 1ns/1ps

module rx_source_mux
(
   input  logic                         clk64,
   input  logic                         rx_dsp_reset,
   rx_cfg_if.mux                        cfg,
   input  logic                         i_dec_strobe,
   input  logic [rx_pkg::SAMPLE_W-1:0]  i_dec_i,
   input  logic [rx_pkg::SAMPLE_W-1:0]  i_dec_q,
   input  logic                         i_tx_strobe,
   input  logic [rx_pkg::SAMPLE_W-1:0]  i_tx_i,
   input  logic [rx_pkg::SAMPLE_W-1:0]  i_tx_q,
   output logic                         o_smp_strobe,
   output logic [rx_pkg::SAMPLE_W-1:0]  o_smp_i,
   output logic [rx_pkg::SAMPLE_W-1:0]  o_smp_q
);

   logic [rx_pkg::SAMPLE_W-1:0] lb_i;
   logic [rx_pkg::SAMPLE_W-1:0] lb_q;
   logic [rx_pkg::SAMPLE_W-1:0] dbg_cnt;

   // Last transmit pair, held until the next transmit strobe
   always_ff @(posedge clk64)
   begin
      if (i_tx_strobe)
      begin
         lb_i <= i_tx_i;
         lb_q <= i_tx_q;
      end
   end

   // Debug counter steps by two per emitted pair
   always_ff @(posedge clk64)
   begin
      if (rx_dsp_reset || !cfg.enable_rx)
         dbg_cnt <= '0;
      else if (i_dec_strobe && cfg.counter_mode)
         dbg_cnt <= dbg_cnt + rx_pkg::SAMPLE_W'(2);
   end

   always_ff @(posedge clk64)
   begin
      if (rx_dsp_reset)
         o_smp_strobe <= 1'b0;
      else
         o_smp_strobe <= i_dec_strobe;
   end

   // Mode is sampled at the decimator strobe
   always_ff @(posedge clk64)
   begin
      if (i_dec_strobe)
      begin
         if (cfg.counter_mode)
         begin
            o_smp_i <= dbg_cnt;
            o_smp_q <= dbg_cnt + 1'b1;
         end
         else if (cfg.loopback)
         begin
            o_smp_i <= lb_i;
            o_smp_q <= lb_q;
         end
         else
         begin
            o_smp_i <= i_dec_i;
            o_smp_q <= i_dec_q;
         end
      end
   end

endmodule

// File: hw/rx_sample_fifo.sv
// First-word-fall-through sample FIFO with sticky overrun flag
`timescale 1ns/1ps

module rx_sample_fifo
(
   input  logic                      clk64,
   input  logic                      rx_dsp_reset,
   input  logic                      i_wr,
   input  logic [rx_pkg::WORD_W-1:0] i_wr_data,
   input  logic                      i_rd,
   input  logic                      i_clear_status,
   output logic [rx_pkg::WORD_W-1:0] o_rd_data,
   output logic                      o_ready,
   output logic                      o_overrun
);

   logic [rx_pkg::WORD_W-1:0]  mem [rx_pkg::FIFO_DEPTH];
   logic [rx_pkg::FIFO_AW-1:0] wr_ptr;
   logic [rx_pkg::FIFO_AW-1:0] rd_ptr;
   logic [rx_pkg::FIFO_AW:0]   fill_count;

   logic full;
   logic empty;
   logic do_wr;
   logic do_rd;

   assign full  = (fill_count == (rx_pkg::FIFO_AW + 1)'(rx_pkg::FIFO_DEPTH));
   assign empty = (fill_count == '0);

   // Writes while full are dropped, reads while empty ignored
   assign do_wr = i_wr && !full;
   assign do_rd = i_rd && !empty;

   always_ff @(posedge clk64)
   begin
      if (do_wr)
      begin
         mem[wr_ptr] <= i_wr_data;
      end
   end

   always_ff @(posedge clk64)
   begin
      if (rx_dsp_reset)
      begin
         wr_ptr     <= '0;
         rd_ptr     <= '0;
         fill_count <= '0;
         o_overrun  <= 1'b0;
      end
      else
      begin
         if (do_wr)
            wr_ptr <= wr_ptr + 1'b1;
         if (do_rd)
            rd_ptr <= rd_ptr + 1'b1;

         case ({do_wr, do_rd})
            2'b10:   fill_count <= fill_count + 1'b1;
            2'b01:   fill_count <= fill_count - 1'b1;
            default: fill_count <= fill_count;
         endcase

         // A fresh overrun wins over a clear in the same cycle
         if (i_wr && full)
            o_overrun <= 1'b1;
         else if (i_clear_status)
            o_overrun <= 1'b0;
      end
   end

   // Head word shown directly
   assign o_rd_data = mem[rd_ptr];
   assign o_ready   = !empty;

endmodule

// File: hw/usrp_rx_path.sv
// Receive sample path top level: settings, decimator, source mux
// and sample FIFO in pipeline order
`timescale 1ns/1ps

module usrp_rx_path
(
   input  logic                               clk64,
   input  logic                               rx_dsp_reset,

   // Serial settings bus
   input  logic                               i_serial_strobe,
   input  logic [rx_pkg::ADDR_W-1:0]          i_serial_addr,
   input  logic [rx_pkg::SERIAL_W-1:0]        i_serial_data,

   // ADC streams
   input  logic signed [rx_pkg::ADC_W-1:0]    i_adc_i,
   input  logic signed [rx_pkg::ADC_W-1:0]    i_adc_q,

   // Transmit samples for loopback
   input  logic                               i_tx_strobe,
   input  logic [rx_pkg::SAMPLE_W-1:0]        i_tx_i,
   input  logic [rx_pkg::SAMPLE_W-1:0]        i_tx_q,

   // Host side
   input  logic                               i_rd,
   input  logic                               i_clear_status,
   output logic [rx_pkg::WORD_W-1:0]          o_rx_data,
   output logic                               o_rx_ready,
   output logic                               o_rx_overrun
);

   logic                        dec_strobe;
   logic [rx_pkg::SAMPLE_W-1:0] dec_i;
   logic [rx_pkg::SAMPLE_W-1:0] dec_q;

   logic                        smp_strobe;
   logic [rx_pkg::SAMPLE_W-1:0] smp_i;
   logic [rx_pkg::SAMPLE_W-1:0] smp_q;

   rx_cfg_if cfg_bus ();

   rx_settings settings_i (
      .clk64           (clk64),
      .rx_dsp_reset    (rx_dsp_reset),
      .i_serial_strobe (i_serial_strobe),
      .i_serial_addr   (i_serial_addr),
      .i_serial_data   (i_serial_data),
      .cfg             (cfg_bus)
   );

   rx_decimator decim_i (
      .clk64        (clk64),
      .rx_dsp_reset (rx_dsp_reset),
      .cfg          (cfg_bus),
      .i_adc_i      (i_adc_i),
      .i_adc_q      (i_adc_q),
      .o_dec_strobe (dec_strobe),
      .o_dec_i      (dec_i),
      .o_dec_q      (dec_q)
   );

   rx_source_mux mux_i (
      .clk64        (clk64),
      .rx_dsp_reset (rx_dsp_reset),
      .cfg          (cfg_bus),
      .i_dec_strobe (dec_strobe),
      .i_dec_i      (dec_i),
      .i_dec_q      (dec_q),
      .i_tx_strobe  (i_tx_strobe),
      .i_tx_i       (i_tx_i),
      .i_tx_q       (i_tx_q),
      .o_smp_strobe (smp_strobe),
      .o_smp_i      (smp_i),
      .o_smp_q      (smp_q)
   );

   // I in the upper half of each word, Q in the lower
   rx_sample_fifo fifo_i (
      .clk64          (clk64),
      .rx_dsp_reset   (rx_dsp_reset),
      .i_wr           (smp_strobe),
      .i_wr_data      ({smp_i, smp_q}),
      .i_rd           (i_rd),
      .i_clear_status (i_clear_status),
      .o_rd_data      (o_rx_data),
      .o_ready        (o_rx_ready),
      .o_overrun      (o_rx_overrun)
   );

endmodule

// File: dv/usrp_rx_path_chk.sv
// Assertions on FIFO occupancy, ready after reset and the decimator
// to mux strobe timing in the receive path
`timescale 1ns/1ps

module usrp_rx_path_chk
(
   input logic                     clk64,
   input logic                     rx_dsp_reset,
   input logic                     i_rx_ready,
   input logic                     i_dec_strobe,
   input logic                     i_smp_strobe,
   input logic [rx_pkg::FIFO_AW:0] i_fill_count
);

   int unsigned fail_count = 0;

   a_fill_bound: assert property (@(posedge clk64) disable iff (rx_dsp_reset)
      i_fill_count <= (rx_pkg::FIFO_AW + 1)'(rx_pkg::FIFO_DEPTH))
      else
      begin
         fail_count++;
         $error("FIFO occupancy above its depth");
      end

   // Empty FIFO right after a reset cycle
   a_ready_low: assert property (@(posedge clk64) rx_dsp_reset |=> !i_rx_ready)
      else
      begin
         fail_count++;
         $error("ready high in the cycle after reset");
      end

   a_mux_follow: assert property (@(posedge clk64) disable iff (rx_dsp_reset)
      i_dec_strobe |=> i_smp_strobe)
      else
      begin
         fail_count++;
         $error("mux strobe missing one cycle after decimator strobe");
      end

endmodule

bind usrp_rx_path usrp_rx_path_chk chk_i (
   .clk64        (clk64),
   .rx_dsp_reset (rx_dsp_reset),
   .i_rx_ready   (o_rx_ready),
   .i_dec_strobe (dec_strobe),
   .i_smp_strobe (smp_strobe),
   .i_fill_count (fifo_i.fill_count)
);

// File: dv/tb_usrp_rx_path.sv
// Testbench for the receive sample path with LFSR stimulus, a cycle model
// of settings, decimator, source mux and FIFO, and the test sequence
`timescale 1ns/1ps

module tb_usrp_rx_path;

   localparam int READ_TIMEOUT = 2000;

   logic               clk64;
   logic               rx_dsp_reset;
   logic               i_serial_strobe;
   logic [6:0]         i_serial_addr;
   logic [31:0]        i_serial_data;
   logic signed [11:0] i_adc_i;
   logic signed [11:0] i_adc_q;
   logic               i_tx_strobe;
   logic [15:0]        i_tx_i;
   logic [15:0]        i_tx_q;
   logic               i_rd;
   logic               i_clear_status;
   logic [31:0]        o_rx_data;
   logic               o_rx_ready;
   logic               o_rx_overrun;

   logic [31:0] lfsr = 32'hffad_c876;

   // Model state
   int          m_decim;
   int          m_shift;
   int          m_win;
   int          acc_i;
   int          acc_q;
   bit          m_loop;
   bit          m_cnt_mode;
   bit          m_en;
   bit          m_ovr;
   bit          pend;
   logic [15:0] pend_i;
   logic [15:0] pend_q;
   logic [15:0] m_cnt;
   logic [15:0] lb_i;
   logic [15:0] lb_q;
   logic [31:0] exp_q[$];

   usrp_rx_path dut_i (.*);

   initial
   begin
      clk64 = 1'b0;
      forever #2 clk64 = ~clk64;
   end

   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int k = 0; k < n; k++)
      begin
         v = {v[30:0], lfsr[0]};
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
      end
      return v;
   endfunction

   // ADC samples every cycle, transmit strobe about one cycle in four
   always @(posedge clk64)
   begin : drive_streams
      logic [31:0] r;
      r = take_bits(24);
      i_adc_i <= r[23:12];
      i_adc_q <= r[11:0];
      r = take_bits(2);
      i_tx_strobe <= (r[1:0] == 2'd0);
      r = take_bits(32);
      i_tx_i <= r[31:16];
      i_tx_q <= r[15:0];
   end

   // Cycle model steps later stages first so each sees last cycle's state
   always @(posedge clk64)
   begin : ref_model
      int sum_i;
      int sum_q;
      bit dropped;
      dropped = 1'b0;
      if (rx_dsp_reset)
      begin
         m_decim    = 0;
         m_shift    = 0;
         m_win      = 0;
         m_loop     = 1'b0;
         m_cnt_mode = 1'b0;
         m_en       = 1'b0;
         m_ovr      = 1'b0;
         pend       = 1'b0;
         m_cnt      = '0;
         exp_q.delete();
      end
      else
      begin
         if (pend && exp_q.size() >= rx_pkg::FIFO_DEPTH)
         begin
            m_ovr = 1'b1;
            dropped = 1'b1;
         end
         else if (pend)
            exp_q.push_back(m_cnt_mode ? {m_cnt, m_cnt + 16'd1} :
                            m_loop ? {lb_i, lb_q} : {pend_i, pend_q});
         if (i_clear_status && !dropped)
            m_ovr = 1'b0;
         if (!m_en)
            m_cnt = '0;
         else if (pend && m_cnt_mode)
            m_cnt = m_cnt + 16'd2;
         if (i_tx_strobe)
         begin
            lb_i = i_tx_i;
            lb_q = i_tx_q;
         end
         pend = 1'b0;
         if (m_en)
         begin
            sum_i = (m_win == 0) ? int'(i_adc_i) : acc_i + int'(i_adc_i);
            sum_q = (m_win == 0) ? int'(i_adc_q) : acc_q + int'(i_adc_q);
            acc_i = sum_i;
            acc_q = sum_q;
            pend = (m_win == m_decim);
            pend_i = 16'(sum_i >>> m_shift);
            pend_q = 16'(sum_q >>> m_shift);
            m_win = pend ? 0 : m_win + 1;
         end
         else
            m_win = 0;
         if (i_serial_strobe && i_serial_addr == rx_pkg::ADDR_RX_DECIM)
            m_decim = int'(i_serial_data[7:0]);
         if (i_serial_strobe && i_serial_addr == rx_pkg::ADDR_RX_MODE)
         begin
            {m_cnt_mode, m_loop} = i_serial_data[1:0];
            m_shift = int'(i_serial_data[11:8]);
         end
         if (i_serial_strobe && i_serial_addr == rx_pkg::ADDR_RX_ENABLE)
            m_en = i_serial_data[0];
      end
   end

   task automatic fail_stop(input string why);
      $display("%s", why);
      $display("RESULT: FAIL");
      $fatal(1, "simulation stopped on first error");
   endtask

   task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
      if (exp !== act)
         fail_stop($sformatf("ERR %s expected 0x%08h actual 0x%08h", name, exp, act));
   endtask

   task automatic write_reg(input logic [6:0] addr, input logic [31:0] data);
      @(posedge clk64);
      i_serial_strobe <= 1'b1;
      i_serial_addr   <= addr;
      i_serial_data   <= data;
      @(posedge clk64);
      i_serial_strobe <= 1'b0;
   endtask

   // Wait for the FIFO head, compare it with the model, then pop it
   task automatic read_word(input string name, output logic [31:0] word);
      int waited;
      waited = 0;
      @(negedge clk64);
      while (!o_rx_ready && waited < READ_TIMEOUT)
      begin
         @(negedge clk64);
         waited++;
      end
      if (!o_rx_ready)
         fail_stop($sformatf("%s: sample data never arrived at the FIFO output", name));
      else if (exp_q.size() == 0)
         fail_stop($sformatf("%s: FIFO holds a word the model did not predict", name));
      else
      begin
         word = o_rx_data;
         check(name, exp_q.pop_front(), word);
         @(posedge clk64);
         i_rd <= 1'b1;
         @(posedge clk64);
         i_rd <= 1'b0;
      end
   endtask

   task automatic stop_and_drain(input string name);
      logic [31:0] word;
      write_reg(rx_pkg::ADDR_RX_ENABLE, 32'd0);
      repeat (8) @(posedge clk64);
      while (exp_q.size() > 0)
         read_word(name, word);
      @(negedge clk64);
      check({name, "_empty"}, 32'd0, 32'(o_rx_ready));
   endtask

   task automatic run_counter(input logic [31:0] mode, input string name);
      logic [31:0] word;
      write_reg(rx_pkg::ADDR_RX_DECIM, 32'd3);
      write_reg(rx_pkg::ADDR_RX_MODE, mode);
      write_reg(rx_pkg::ADDR_RX_ENABLE, 32'd1);
      for (int n = 0; n < 5; n++)
      begin
         read_word(name, word);
         check(name, {16'(2 * n), 16'(2 * n + 1)}, word);
      end
      stop_and_drain(name);
   endtask

   initial
   begin : main
      logic [31:0] word;
      logic [31:0] decim_val;
      logic [31:0] mode_val;
      int          waited;
      rx_dsp_reset    = 1'b1;
      i_serial_strobe = 1'b0;
      i_serial_addr   = '0;
      i_serial_data   = '0;
      i_adc_i         = '0;
      i_adc_q         = '0;
      i_tx_strobe     = 1'b0;
      i_tx_i          = '0;
      i_tx_q          = '0;
      i_rd            = 1'b0;
      i_clear_status  = 1'b0;
      repeat (16) @(posedge clk64);
      rx_dsp_reset <= 1'b0;

      // Empty after reset and unchanged by reads while empty
      @(negedge clk64);
      check("reset_ready", 32'd0, 32'(o_rx_ready));
      check("reset_overrun", 32'd0, 32'(o_rx_overrun));
      @(posedge clk64);
      i_rd <= 1'b1;
      repeat (3) @(posedge clk64);
      i_rd <= 1'b0;
      @(negedge clk64);
      check("empty_read_ready", 32'd0, 32'(o_rx_ready));
      check("empty_read_overrun", 32'd0, 32'(o_rx_overrun));

      for (int r = 0; r < 5; r++)
      begin
         decim_val = 32'd3 + take_bits(6);
         mode_val  = take_bits(4) << 8;
         write_reg(rx_pkg::ADDR_RX_DECIM, decim_val);
         write_reg(rx_pkg::ADDR_RX_MODE, mode_val);
         write_reg(rx_pkg::ADDR_RX_ENABLE, 32'd1);
         repeat (6) read_word("normal", word);
         stop_and_drain("normal_drain");
      end

      // Second run checks the restart at zero and priority over loopback
      run_counter(32'h2, "counter");
      run_counter(32'h3, "counter_priority");

      write_reg(rx_pkg::ADDR_RX_DECIM, 32'd7);
      write_reg(rx_pkg::ADDR_RX_MODE, 32'h1);
      write_reg(rx_pkg::ADDR_RX_ENABLE, 32'd1);
      repeat (6) read_word("loopback", word);
      stop_and_drain("loopback_drain");

      // Fill past the depth without reads
      write_reg(rx_pkg::ADDR_RX_DECIM, 32'd1);
      write_reg(rx_pkg::ADDR_RX_MODE, 32'h0);
      write_reg(rx_pkg::ADDR_RX_ENABLE, 32'd1);
      waited = 0;
      @(negedge clk64);
      while (!o_rx_overrun && waited < READ_TIMEOUT)
      begin
         @(negedge clk64);
         waited++;
      end
      if (!o_rx_overrun)
         fail_stop("overrun flag never rose while the FIFO was full");
      write_reg(rx_pkg::ADDR_RX_ENABLE, 32'd0);
      repeat (8) @(posedge clk64);
      @(negedge clk64);
      check("overrun_model", 32'(m_ovr), 32'(o_rx_overrun));
      repeat (16) read_word("fill_order", word);
      @(negedge clk64);
      check("full_drain_ready", 32'd0, 32'(o_rx_ready));
      check("overrun_sticky", 32'd1, 32'(o_rx_overrun));
      @(posedge clk64);
      i_clear_status <= 1'b1;
      @(posedge clk64);
      i_clear_status <= 1'b0;
      @(negedge clk64);
      check("overrun_clear", 32'(m_ovr), 32'(o_rx_overrun));
      check("overrun_cleared", 32'd0, 32'(o_rx_overrun));

      if (dut_i.chk_i.fail_count != 0)
         fail_stop("an assertion in the bound checker failed during the run");
      else
      begin
         $display("RESULT: PASS");
         $finish;
      end
   end

endmodule

// File: usrp_rx_path.f
hw/rx_pkg.sv
hw/rx_cfg_if.sv
hw/rx_settings.sv
hw/rx_decimator.sv
hw/rx_source_mux.sv
hw/rx_sample_fifo.sv
hw/usrp_rx_path.sv
dv/usrp_rx_path_chk.sv
dv/tb_usrp_rx_path.sv

// File: Makefile
# Verilator build and run for the receive sample path
VERILATOR ?= verilator
TOP       ?= tb_usrp_rx_path
FILELIST  ?= usrp_rx_path.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
PASS_MSG  ?= RESULT: PASS

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
